// File: posit_pkg.sv
package posit_pkg;

    // cycles from a sampled in_valid to the matching out_valid
    localparam int DIV_LATENCY = 2;

    // regime times 2^es plus exponent, with a sign bit and a guard bit
    // so that the difference of two exponents cannot wrap
    function automatic int te_size(input int n, input int es);
        return $clog2((n - 1) << es) + 2;
    endfunction

    // fraction bits left by the shortest regime, plus the hidden bit
    function automatic int mant_size(input int n, input int es);
        return n - 2 - es;
    endfunction

    // reciprocal seed width, one integer bit and the rest fraction
    function automatic int recip_size(input int n, input int es);
        return 3 * mant_size(n, es) - 4;
    endfunction

    // dividend mantissa times the refined reciprocal of 2*mant_size bits
    function automatic int div_result_size(input int n, input int es);
        return 3 * mant_size(n, es);
    endfunction

endpackage

// File: posit_decode.sv
`timescale 1ns/1ns

module posit_decode #(
    parameter int N  = 16,
    parameter int ES = 1
) (
    input  logic [N-1:0]                          posit,
    output logic                                  sign,
    output logic [posit_pkg::te_size(N, ES)-1:0]  te,
    output logic [posit_pkg::mant_size(N, ES)-1:0] mant,
    output logic                                  is_zero,
    output logic                                  is_nar
);

    localparam int TE = posit_pkg::te_size(N, ES);
    localparam int MS = posit_pkg::mant_size(N, ES);

    logic [N-1:0]         magnitude;
    logic [N-2:0]         body;
    logic [TE-1:0]        run;
    logic                 run_open;
    logic signed [TE-1:0] k;
    logic [N-2:0]         shifted;
    logic [ES-1:0]        exp_bits;

    assign sign    = posit[N-1];
    assign is_zero = posit == '0;
    assign is_nar  = posit == {1'b1, {(N-1){1'b0}}};

    // negative posits are decoded from their two's complement
    assign magnitude = sign ? -posit : posit;
    assign body      = magnitude[N-2:0];

    // length of the regime run, counted from the bit below the sign
    always_comb begin
        run      = '0;
        run_open = 1'b1;
        for (int i = N - 2; i >= 0; i--) begin
            if (run_open && body[i] == body[N-2]) begin
                run = run + 1'b1;
            end else begin
                run_open = 1'b0;
            end
        end
    end

    // a run of ones means k = run-1, a run of zeros means k = -run
    assign k = body[N-2] ? run - 1'b1 : -run;

    // drop the run and its terminating bit
    assign shifted  = body << (run + 1'b1);
    assign exp_bits = shifted[N-2 -: ES];

    // low ES bits of k*2^ES are zero, so the exponent just fills them
    assign te = {k[TE-1-ES:0], exp_bits};

    // the two lowest bits of shifted are always zero after the shift
    assign mant = {1'b1, shifted[N-2-ES -: MS-1]};

endmodule

// File: fast_reciprocal.sv
`timescale 1ns/1ns

module fast_reciprocal #(
    parameter int SIZE = 13
) (
    input  logic [SIZE-1:0]   fraction,
    output logic [3*SIZE-5:0] one_over_fraction
);

    localparam int RS = 3 * SIZE - 4;
    // fraction bits of the seed coefficients
    localparam int CF = 16;
    // seed has 2 integer bits and CF+SIZE-1 fraction bits
    localparam int SW = CF + SIZE + 1;

    logic [1:0]       segment;
    logic [CF+1:0]    intercept;
    logic [CF-1:0]    slope;
    logic [SW-1:0]    seed;
    logic [SW+RS-1:0] seed_ext;
    logic             mant_is_one;

    // top two fraction bits pick a quarter of [1, 2)
    assign segment     = fraction[SIZE-2 -: 2];
    assign mant_is_one = fraction[SIZE-2:0] == '0;

    // per quarter [a, b): 1/x ~ c - x/(a*b), c chosen for equal ripple
    always_comb begin
        case (segment)
            2'd0: begin
                intercept = 18'd117600;
                slope     = 16'd52429;
            end
            2'd1: begin
                intercept = 18'd95920;
                slope     = 16'd34953;
            end
            2'd2: begin
                intercept = 18'd81020;
                slope     = 16'd24966;
            end
            default: begin
                intercept = 18'd70139;
                slope     = 16'd18725;
            end
        endcase
    end

    // line evaluated at the mantissa, stays between 0.49 and 1
    assign seed = {intercept, {(SIZE-1){1'b0}}} - slope * fraction;

    // realign to RS-1 fraction bits
    assign seed_ext = {seed, {RS{1'b0}}};

    // 1/1 needs the integer bit, so it is set directly and stays exact
    assign one_over_fraction = mant_is_one ? {1'b1, {(RS-1){1'b0}}}
                                           : RS'(seed_ext >> (CF + SIZE));

endmodule

// File: newton_raphson.sv
`timescale 1ns/1ns

module newton_raphson #(
    parameter int MS = 13
) (
    input  logic [MS-1:0]   num,
    input  logic [3*MS-5:0] x0,
    output logic [2*MS-1:0] x1
);

    localparam int RS = 3 * MS - 4;
    // num*x0 holds MS+RS-2 fraction bits
    localparam int PW = MS + RS;
    localparam int XW = PW + RS;
    // bits to drop so that x1 keeps 2*MS-1 fraction bits
    localparam int DROP = 2 * RS - MS - 2;

    logic [PW-1:0] num_x0;
    logic [PW-1:0] two_minus;
    logic [XW-1:0] x1_full;

    // close to one when the seed is good
    assign num_x0 = num * x0;

    // two is the top bit of the product format
    assign two_minus = {1'b1, {(PW-1){1'b0}}} - num_x0;

    // x1 = x0 * (2 - num*x0), error goes from e to e^2
    assign x1_full = x0 * two_minus;

    // an exact seed of one gives two_minus of exactly one
    assign x1 = x1_full[DROP +: 2*MS];

endmodule

// File: core_div.sv
`timescale 1ns/1ns

module core_div #(
    parameter int N  = 16,
    parameter int ES = 1
) (
    input  logic [posit_pkg::te_size(N, ES)-1:0]         te1,
    input  logic [posit_pkg::te_size(N, ES)-1:0]         te2,
    input  logic [posit_pkg::mant_size(N, ES)-1:0]       mant1,
    input  logic [posit_pkg::mant_size(N, ES)-1:0]       mant2,
    output logic [posit_pkg::div_result_size(N, ES)-1:0] mant_out,
    output logic [posit_pkg::te_size(N, ES)-1:0]         te_out
);

    localparam int TE = posit_pkg::te_size(N, ES);
    localparam int MS = posit_pkg::mant_size(N, ES);
    localparam int RS = posit_pkg::recip_size(N, ES);
    localparam int DR = posit_pkg::div_result_size(N, ES);

    logic [TE-1:0]   te_diff;
    logic [RS-1:0]   mant2_reciprocal;
    logic [2*MS-1:0] x1;
    logic [DR-1:0]   mant_div;
    logic            mant_div_less_than_one;

    assign te_diff = te1 - te2;

    fast_reciprocal #(
        .SIZE(MS)
    ) fast_reciprocal_inst (
        .fraction          (mant2),
        .one_over_fraction (mant2_reciprocal)
    );

    newton_raphson #(
        .MS(MS)
    ) newton_raphson_inst (
        .num (mant2),
        .x0  (mant2_reciprocal),
        .x1  (x1)
    );

    // 3*MS-2 fraction bits, value in (0.5, 2)
    assign mant_div = mant1 * x1;

    // unit bit clear means the quotient mantissa is below one
    assign mant_div_less_than_one = ~mant_div[DR-2];

    assign mant_out = mant_div_less_than_one ? mant_div << 1 : mant_div;
    assign te_out   = mant_div_less_than_one ? te_diff - 1'b1 : te_diff;

endmodule

// File: posit_round_encode.sv
`timescale 1ns/1ns

module posit_round_encode #(
    parameter int N  = 16,
    parameter int ES = 1
) (
    input  logic                                         sign,
    input  logic [posit_pkg::te_size(N, ES)-1:0]         te,
    input  logic [posit_pkg::div_result_size(N, ES)-1:0] mant,
    output logic [N-1:0]                                 posit
);

    localparam int TE = posit_pkg::te_size(N, ES);
    localparam int DR = posit_pkg::div_result_size(N, ES);
    // fraction bits below the hidden bit
    localparam int FB = DR - 2;
    // regime, terminator, exponent and fraction laid out side by side
    localparam int WX = N + ES + FB;

    // largest and smallest regime values that still hold a terminator
    localparam logic signed [TE-1:0] K_MAX = TE'(N - 2);
    localparam logic signed [TE-1:0] K_MIN = TE'(-(N - 2));

    logic signed [TE-1:0] k;
    logic [TE-1:0]        run;
    logic                 rbit;
    logic [ES-1:0]        exp_bits;
    logic [WX-1:0]        tail;
    logic [WX-1:0]        regime_mask;
    logic [WX-1:0]        body_ext;
    logic [N-2:0]         body;
    logic                 lsb;
    logic                 guard;
    logic                 sticky;
    logic                 round_up;
    logic [N-2:0]         body_rounded;
    logic [N-2:0]         body_sat;
    logic [N-1:0]         magnitude;

    // te = k*2^ES + e
    assign k        = $signed(te) >>> ES;
    assign exp_bits = te[ES-1:0];

    // regime bit value and run length
    assign rbit = ~k[TE-1];
    assign run  = rbit ? k + 1'b1 : -k;

    // terminator, exponent and fraction move down behind the run
    assign tail = {~rbit, exp_bits, mant[FB-1:0], {(N-1){1'b0}}} >> run;

    // a run of ones has to be filled in from the top
    assign regime_mask = ~({WX{1'b1}} >> run);
    assign body_ext    = tail | ({WX{rbit}} & regime_mask);

    assign body   = body_ext[WX-1 -: N-1];
    assign lsb    = body_ext[WX-N+1];
    assign guard  = body_ext[WX-N];
    assign sticky = |body_ext[WX-N-1:0];

    // nearest even, a carry moves on into exponent and regime
    assign round_up     = guard & (lsb | sticky);
    assign body_rounded = body + round_up;

    // out of range clamps to maxpos or minpos, never to zero or NaR
    always_comb begin
        if (k >= K_MAX) begin
            body_sat = {(N-1){1'b1}};
        end else if (k < K_MIN) begin
            body_sat = {{(N-2){1'b0}}, 1'b1};
        end else begin
            body_sat = body_rounded;
        end
    end

    assign magnitude = {1'b0, body_sat};
    assign posit     = sign ? -magnitude : magnitude;

endmodule

// File: posit_div.sv
`timescale 1ns/1ns

module posit_div #(
    parameter int N  = 16,
    parameter int ES = 1
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         in_valid,
    input  logic [N-1:0] dividend,
    input  logic [N-1:0] divisor,
    output logic         out_valid,
    output logic [N-1:0] quotient
);

    localparam int TE  = posit_pkg::te_size(N, ES);
    localparam int MS  = posit_pkg::mant_size(N, ES);
    localparam int DR  = posit_pkg::div_result_size(N, ES);
    localparam int LAT = posit_pkg::DIV_LATENCY;

    // stage 0, decoded operands
    logic          sign_a;
    logic          sign_b;
    logic [TE-1:0] te_a;
    logic [TE-1:0] te_b;
    logic [MS-1:0] mant_a;
    logic [MS-1:0] mant_b;
    logic          zero_a;
    logic          zero_b;
    logic          nar_a;
    logic          nar_b;

    // stage 1 registers
    logic          sign_a_s1;
    logic          sign_b_s1;
    logic [TE-1:0] te_a_s1;
    logic [TE-1:0] te_b_s1;
    logic [MS-1:0] mant_a_s1;
    logic [MS-1:0] mant_b_s1;
    logic          zero_a_s1;
    logic          zero_b_s1;
    logic          nar_a_s1;
    logic          nar_b_s1;
    logic          valid_s1;

    logic [LAT-1:0] valid_pipe;
    logic [TE-1:0]  te_q;
    logic [DR-1:0]  mant_q;
    logic [N-1:0]   encoded;
    logic           result_nar;
    logic [N-1:0]   result_s1;

    posit_decode #(.N(N), .ES(ES)) decode_a (
        .posit   (dividend),
        .sign    (sign_a),
        .te      (te_a),
        .mant    (mant_a),
        .is_zero (zero_a),
        .is_nar  (nar_a)
    );

    posit_decode #(.N(N), .ES(ES)) decode_b (
        .posit   (divisor),
        .sign    (sign_b),
        .te      (te_b),
        .mant    (mant_b),
        .is_zero (zero_b),
        .is_nar  (nar_b)
    );

    always_ff @(posedge clk) begin
        if (in_valid) begin
            sign_a_s1 <= sign_a;
            sign_b_s1 <= sign_b;
            te_a_s1   <= te_a;
            te_b_s1   <= te_b;
            mant_a_s1 <= mant_a;
            mant_b_s1 <= mant_b;
            zero_a_s1 <= zero_a;
            zero_b_s1 <= zero_b;
            nar_a_s1  <= nar_a;
            nar_b_s1  <= nar_b;
        end
    end

    // one bit per stage, no stalls
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[LAT-2:0], in_valid};
        end
    end

    assign valid_s1  = valid_pipe[0];
    assign out_valid = valid_pipe[LAT-1];

    core_div #(.N(N), .ES(ES)) core_div_inst (
        .te1      (te_a_s1),
        .te2      (te_b_s1),
        .mant1    (mant_a_s1),
        .mant2    (mant_b_s1),
        .mant_out (mant_q),
        .te_out   (te_q)
    );

    posit_round_encode #(.N(N), .ES(ES)) encode_inst (
        .sign  (sign_a_s1 ^ sign_b_s1),
        .te    (te_q),
        .mant  (mant_q),
        .posit (encoded)
    );

    // NaR wins over zero: x/0, NaR/x and x/NaR are all NaR
    assign result_nar = nar_a_s1 | nar_b_s1 | zero_b_s1;
    assign result_s1  = result_nar ? {1'b1, {(N-1){1'b0}}} :
                        zero_a_s1  ? '0 : encoded;

    always_ff @(posedge clk) begin
        if (rst) begin
            quotient <= '0;
        end else if (valid_s1) begin
            quotient <= result_s1;
        end
    end

endmodule

// File: posit_div_properties.sv
`timescale 1ns/1ns

module posit_div_properties #(
    parameter int N = 16
) (
    input logic         clk,
    input logic         rst,
    input logic         in_valid,
    input logic [N-1:0] dividend,
    input logic [N-1:0] divisor,
    input logic         out_valid,
    input logic [N-1:0] quotient
);

    localparam logic [N-1:0] NAR = {1'b1, {(N-1){1'b0}}};
    localparam logic [N-1:0] ONE = {2'b01, {(N-2){1'b0}}};

    // operands seen one and two edges ago, [1] lines up with out_valid
    logic [1:0]        valid_hist;
    logic [1:0][N-1:0] a_hist;
    logic [1:0][N-1:0] b_hist;
    logic              special;
    logic              normal;
    int                failures = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_hist <= '0;
        end else begin
            valid_hist <= {valid_hist[0], in_valid};
        end
    end

    always_ff @(posedge clk) begin
        a_hist <= {a_hist[0], dividend};
        b_hist <= {b_hist[0], divisor};
    end

    assign special = a_hist[1] == NAR || b_hist[1] == NAR || b_hist[1] == '0;
    assign normal  = !special && a_hist[1] != '0;

    latency_check: assert property (@(posedge clk) disable iff (rst)
        out_valid == valid_hist[1])
        else begin
            failures = failures + 1;
            $error("out_valid is not exactly two cycles after in_valid");
        end

    // NaR first, then a zero dividend
    special_check: assert property (@(posedge clk) disable iff (rst)
        out_valid && !normal |-> quotient == (special ? NAR : '0))
        else begin
            failures = failures + 1;
            $error("wrong NaR or zero result for a special operand");
        end

    sign_check: assert property (@(posedge clk) disable iff (rst)
        out_valid && normal |-> quotient[N-1] == (a_hist[1][N-1] ^ b_hist[1][N-1])
            && quotient != '0 && quotient != NAR)
        else begin
            failures = failures + 1;
            $error("quotient sign is wrong or the result is zero or NaR");
        end

    one_check: assert property (@(posedge clk) disable iff (rst)
        out_valid && normal && b_hist[1] == ONE |-> quotient == a_hist[1])
        else begin
            failures = failures + 1;
            $error("division by one changed the dividend");
        end

endmodule

// File: tb_posit_div.sv
`timescale 1ns/1ns

module tb_posit_div;

    localparam int N            = 16;
    localparam int ES           = 1;
    localparam int NUM_RANDOM   = 400;
    localparam int NUM_DIRECTED = 34;
    // each random operation takes at most two cycles, plus reset and drain
    localparam int TIMEOUT_CYCLES = 2 * NUM_RANDOM + NUM_DIRECTED + 20;
    localparam logic [N-1:0] NAR = {1'b1, {(N-1){1'b0}}};
    localparam logic [N-1:0] ONE = {2'b01, {(N-2){1'b0}}};
    // 1, 2, 4, 1/2, 1/4, -1, -2 and 1/8 for N=16, ES=1
    localparam logic [N-1:0] POW2 [8] = '{16'h4000, 16'h5000, 16'h6000, 16'h3000,
                                          16'h2000, 16'hc000, 16'hb000, 16'h1800};

    logic         clk;
    logic         rst;
    logic         in_valid;
    logic [N-1:0] dividend;
    logic [N-1:0] divisor;
    logic         out_valid;
    logic [N-1:0] quotient;
    logic [31:0]  lfsr = 32'd90734;
    // {exact, dividend, divisor} for each operation in flight
    logic [2*N:0] pending[$];
    logic [2*N:0] entry;
    logic [N-1:0] expected;
    logic [N-1:0] operand;
    int           diff;
    int           cycles = 0;
    int           issued = 0;
    int           checked = 0;
    int           i;

    posit_div #(.N(N), .ES(ES)) i_posit_div (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .dividend  (dividend),
        .divisor   (divisor),
        .out_valid (out_valid),
        .quotient  (quotient)
    );

    bind posit_div posit_div_properties #(.N(N)) props (
        .clk(clk), .rst(rst), .in_valid(in_valid), .dividend(dividend),
        .divisor(divisor), .out_valid(out_valid), .quotient(quotient)
    );

    task automatic report_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        logic b;
        b = lfsr[0];
        lfsr = (lfsr >> 1) ^ (b ? 32'h80200003 : 32'h0);
        return b;
    endfunction

    function automatic logic [N-1:0] random_word();
        logic [N-1:0] w;
        int b;
        for (b = 0; b < N; b++) begin
            w[b] = next_bit();
        end
        return w;
    endfunction

    // real value of a posit code of the given width, zero and NaR excluded
    function automatic real posit_value(input logic [N:0] code, input int width);
        logic [N:0] mag;
        logic       r0;
        real        v;
        real        w;
        int         k;
        int         e;
        int         p;
        int         j;
        mag = code[width-1] ? (1 << width) - code : code;
        p = width - 2;
        r0 = mag[p];
        k = r0 ? -1 : 0;
        while (p >= 0 && mag[p] == r0) begin
            k = r0 ? k + 1 : k - 1;
            p--;
        end
        // skip the terminator, missing exponent bits read as zero
        p--;
        e = 0;
        for (j = 0; j < ES; j++) begin
            e = 2 * e + ((p >= 0) ? int'(mag[p]) : 0);
            p--;
        end
        v = 1.0;
        w = 0.5;
        while (p >= 0) begin
            if (mag[p]) begin
                v = v + w;
            end
            w = w / 2.0;
            p--;
        end
        for (j = 0; j < (k << ES) + e; j++) begin
            v = v * 2.0;
        end
        for (j = 0; j > (k << ES) + e; j--) begin
            v = v / 2.0;
        end
        return code[width-1] ? -v : v;
    endfunction

    // nearest even on the bit string, saturating at minpos and maxpos
    function automatic logic [N-1:0] nearest_posit(input real x);
        real mag;
        real tie;
        int  lo;
        int  hi;
        int  mid;
        mag = (x < 0.0) ? -x : x;
        lo = 1;
        hi = (1 << (N - 1)) - 1;
        if (mag >= posit_value(hi, N)) begin
            lo = hi;
        end else if (mag > posit_value(1, N)) begin
            while (hi - lo > 1) begin
                mid = (lo + hi) / 2;
                if (posit_value(mid, N) <= mag) begin
                    lo = mid;
                end else begin
                    hi = mid;
                end
            end
            // the odd code one bit longer sits halfway between lo and lo+1
            tie = posit_value(2 * lo + 1, N + 1);
            if (mag > tie || (mag == tie && lo % 2 == 1)) begin
                lo++;
            end
        end
        return (x < 0.0) ? N'(-lo) : N'(lo);
    endfunction

    function automatic logic [N-1:0] model_quotient(input logic [N-1:0] a,
                                                    input logic [N-1:0] b);
        if (a == NAR || b == NAR || b == '0) begin
            return NAR;
        end
        if (a == '0) begin
            return '0;
        end
        return nearest_posit(posit_value(a, N) / posit_value(b, N));
    endfunction

    // called 2 ns after an edge, returns 2 ns after the sampling edge
    task automatic issue(input logic [N-1:0] a, input logic [N-1:0] b, input logic exact);
        dividend = a;
        divisor = b;
        in_valid = 1'b1;
        pending.push_back({exact, a, b});
        issued++;
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("error: timeout, the test did not end within %0d cycles", TIMEOUT_CYCLES);
            report_failure();
        end
    end

    // scoreboard, outputs are stable at the falling edge
    always @(negedge clk) begin
        if (i_posit_div.props.failures != 0) begin
            $display("error: an assertion on the DUT failed before %0t", $time);
            report_failure();
        end else if (!rst && out_valid) begin
            if (pending.size() == 0) begin
                $display("error: out_valid at %0t with no operation in flight", $time);
                report_failure();
            end else begin
                entry = pending.pop_front();
                expected = model_quotient(entry[2*N-1:N], entry[N-1:0]);
                diff = int'($signed(quotient)) - int'($signed(expected));
                // inexact quotients may land on a neighbouring code
                if (quotient != expected && (entry[2*N] || expected == NAR
                        || expected == '0 || diff > 1 || diff < -1)) begin
                    $display("mismatch at %0t: %h / %h gave %h, expected %h", $time,
                             entry[2*N-1:N], entry[N-1:0], quotient, expected);
                    report_failure();
                end
                checked++;
            end
        end
    end

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        dividend = '0;
        divisor = '0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        for (i = 0; i < 4; i++) begin
            issue('0, random_word(), 1'b1);
        end
        for (i = 0; i < 4; i++) begin
            issue(random_word(), '0, 1'b1);
        end
        for (i = 0; i < 3; i++) begin
            issue(NAR, random_word(), 1'b1);
            issue(random_word(), NAR, 1'b1);
        end
        for (i = 0; i < 6; i++) begin
            issue(random_word(), ONE, 1'b1);
        end
        for (i = 0; i < 8; i++) begin
            issue(random_word(), POW2[i], 1'b1);
        end
        for (i = 0; i < 6; i++) begin
            operand = random_word();
            issue(operand, operand, 1'b1);
        end
        for (i = 0; i < NUM_RANDOM; i++) begin
            issue(random_word(), random_word(), 1'b0);
            // mostly back to back, an idle cycle one time in four
            if (!next_bit() & !next_bit()) begin
                @(posedge clk);
                #2;
            end
        end
        while (checked != issued) begin
            @(negedge clk);
        end
        // let the last assertions fire
        repeat (3) @(posedge clk);
        #2;
        if (i_posit_div.props.failures == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("error: an assertion on the DUT failed after the last result");
            report_failure();
        end
    end

endmodule

// File: verilog.f
posit_pkg.sv
posit_decode.sv
fast_reciprocal.sv
newton_raphson.sv
core_div.sv
posit_round_encode.sv
posit_div.sv
posit_div_properties.sv
tb_posit_div.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_posit_div -f verilog.f -o tb_posit_div
	./obj_dir/tb_posit_div +verilator+error+limit+100 > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
